// ==== design/data_addr_calc.sv ====
`include "sparse_defs.svh"

module data_addr_calc
	import sparse_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_i,
	input  pos_t  match_pos_i,
	input  logic  match_end_i,
	input  logic  sub_chunk_start_i,
	input  logic  sub_chunk_end_i,
	input  fil_t  filter_id_i,
	input  cnt_t  counts_i [`MAP_WIDTH],
	input  cnt_t  total_i,
	output addr_t rd_addr_o
);

	// Running base of the current sub-chunk
	addr_t base_r;

	// End address of each filter's most recent sub-chunk
	addr_t next_base_r [`FILTER_SLOTS];

	addr_t prev_end_w;
	addr_t eff_base_w;
	addr_t win_end_w;

	//////////////////////////////
	// Address forming
	//////////////////////////////

	// Filter 0 always starts at the bottom of memory
	assign prev_end_w = (filter_id_i == '0) ? '0 : next_base_r[filter_id_i - fil_t'(1)];

	// New sub-chunk takes its base from the stacking table
	assign eff_base_w = sub_chunk_start_i ? prev_end_w : base_r;

	assign rd_addr_o = eff_base_w + addr_t'(counts_i[match_pos_i]);

	// First free word after the current window
	assign win_end_w = eff_base_w + addr_t'(total_i);

	//////////////////////////////
	// Base register
	//////////////////////////////

	// Start cycle loads the table value so later matches of
	// the same window see it
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_r <= '0;
		end else if (match_end_i) begin
			base_r <= win_end_w;
		end else if (sub_chunk_start_i) begin
			base_r <= eff_base_w;
		end
	end

	//////////////////////////////
	// Stacking table
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int f = 0; f < `FILTER_SLOTS; f++) begin
				next_base_r[f] <= '0;
			end
		end else if (match_end_i && sub_chunk_end_i) begin
			next_base_r[filter_id_i] <= win_end_w;
		end
	end

endmodule

// ==== design/match_pri_enc.sv ====
`include "sparse_defs.svh"

module match_pri_enc
	import sparse_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic load_i,
	input  map_t mask_i,
	output logic match_valid_o,
	output pos_t match_pos_o,
	output logic match_end_o
);

	map_t mask_r;
	logic armed_r;
	map_t low_bit_w;
	map_t rest_w;

	//////////////////////////////
	// Lowest-bit select
	//////////////////////////////

	// Two's complement trick keeps only the lowest set bit
	assign low_bit_w = mask_r & (~mask_r + map_t'(1));

	// Matches still pending after this cycle
	assign rest_w = mask_r & ~low_bit_w;

	always_comb begin
		match_pos_o = '0;
		for (int i = 0; i < `MAP_WIDTH; i++) begin
			if (low_bit_w[i]) begin
				match_pos_o = pos_t'(i);
			end
		end
	end

	assign match_valid_o = armed_r & (|mask_r);

	// Fires with the last match, or alone for an empty mask
	assign match_end_o = armed_r & (rest_w == '0);

	//////////////////////////////
	// State
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			armed_r <= 1'b0;
		end else if (load_i) begin
			armed_r <= 1'b1;
		end else if (match_end_o) begin
			armed_r <= 1'b0;
		end
	end

	// Mask drains one bit per emitted match
	always_ff @(posedge clk_i) begin
		if (load_i) begin
			mask_r <= mask_i;
		end else if (match_valid_o) begin
			mask_r <= rest_w;
		end
	end

endmodule

// ==== design/sparse_chunk_reader.sv ====
`include "sparse_defs.svh"

module sparse_chunk_reader
	import sparse_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_i,
	input  logic  win_valid_i,
	input  map_t  ifm_map_i,
	input  map_t  fil_map_i,
	input  fil_t  filter_id_i,
	input  logic  sub_chunk_first_i,
	input  logic  sub_chunk_last_i,
	output logic  rd_valid_o,
	output addr_t rd_addr_o,
	output logic  win_done_o
);

	logic load_w;
	map_t mask_w;
	map_t ifm_lat_w;
	fil_t fil_id_w;
	logic start_w;
	logic end_w;
	logic match_valid_w;
	pos_t match_pos_w;
	logic match_end_w;
	cnt_t counts_w [`MAP_WIDTH];
	cnt_t total_w;

	window_sequencer u_seq (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.win_valid_i       (win_valid_i),
		.ifm_map_i         (ifm_map_i),
		.fil_map_i         (fil_map_i),
		.filter_id_i       (filter_id_i),
		.sub_chunk_first_i (sub_chunk_first_i),
		.sub_chunk_last_i  (sub_chunk_last_i),
		.match_valid_i     (match_valid_w),
		.match_end_i       (match_end_w),
		.load_o            (load_w),
		.mask_o            (mask_w),
		.ifm_map_o         (ifm_lat_w),
		.filter_id_o       (fil_id_w),
		.sub_chunk_start_o (start_w),
		.sub_chunk_end_o   (end_w),
		.rd_valid_o        (rd_valid_o),
		.win_done_o        (win_done_o)
	);

	match_pri_enc u_enc (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.load_i        (load_w),
		.mask_i        (mask_w),
		.match_valid_o (match_valid_w),
		.match_pos_o   (match_pos_w),
		.match_end_o   (match_end_w)
	);

	// Prefix counts come from the latched feature map
	spmap_prefix_sum u_psum (
		.map_i    (ifm_lat_w),
		.counts_o (counts_w),
		.total_o  (total_w)
	);

	data_addr_calc u_addr (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.match_pos_i       (match_pos_w),
		.match_end_i       (match_end_w),
		.sub_chunk_start_i (start_w),
		.sub_chunk_end_i   (end_w),
		.filter_id_i       (fil_id_w),
		.counts_i          (counts_w),
		.total_i           (total_w),
		.rd_addr_o         (rd_addr_o)
	);

endmodule

// ==== design/sparse_defs.svh ====
`ifndef SPARSE_DEFS_SVH
`define SPARSE_DEFS_SVH

//////////////////////////////
// Window geometry
//////////////////////////////

// Bits per sparsity map with one bit per window element
`define MAP_WIDTH 8

//////////////////////////////
// Compressed storage
//////////////////////////////

// Words in the compressed data memory
// Address width is clog2 of this plus one bit
`define CHUNK_DEPTH 64

// Entries in the channel stacking table
`define FILTER_SLOTS 4

`endif

// ==== design/sparse_pkg.sv ====
`include "sparse_defs.svh"

package sparse_pkg;

	//////////////////////////////
	// Map side
	//////////////////////////////

	// One sparsity map where a set bit marks a nonzero element
	typedef logic [`MAP_WIDTH-1:0] map_t;

	// Element position inside a map
	typedef logic [$clog2(`MAP_WIDTH)-1:0] pos_t;

	// Set-bit count from 0 up to MAP_WIDTH inclusive
	typedef logic [$clog2(`MAP_WIDTH):0] cnt_t;

	//////////////////////////////
	// Memory side
	//////////////////////////////

	// Compressed memory word address
	typedef logic [$clog2(`CHUNK_DEPTH):0] addr_t;

	// Filter slot in the stacking table
	typedef logic [$clog2(`FILTER_SLOTS)-1:0] fil_t;

endpackage

// ==== design/spmap_prefix_sum.sv ====
`include "sparse_defs.svh"

module spmap_prefix_sum
	import sparse_pkg::*;
(
	input  map_t map_i,
	output cnt_t counts_o [`MAP_WIDTH],
	output cnt_t total_o
);

	localparam int LVLS = $clog2(`MAP_WIDTH);

	// Inclusive partial sums with the map itself in row 0
	cnt_t sum_w [LVLS+1][`MAP_WIDTH];

	//////////////////////////////
	// Log-depth scan
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < `MAP_WIDTH; i++) begin
			sum_w[0][i] = cnt_t'(map_i[i]);
		end
		// Each level adds the partial sum from 2**l positions below
		for (int l = 0; l < LVLS; l++) begin
			for (int i = 0; i < `MAP_WIDTH; i++) begin
				if (i >= (1 << l)) begin
					sum_w[l+1][i] = sum_w[l][i] + sum_w[l][i - (1 << l)];
				end else begin
					sum_w[l+1][i] = sum_w[l][i];
				end
			end
		end
	end

	//////////////////////////////
	// Exclusive counts
	//////////////////////////////

	// Count below position i is the inclusive sum at i-1
	always_comb begin
		counts_o[0] = '0;
		for (int i = 1; i < `MAP_WIDTH; i++) begin
			counts_o[i] = sum_w[LVLS][i-1];
		end
	end

	// Whole-window popcount
	assign total_o = sum_w[LVLS][`MAP_WIDTH-1];

endmodule

// ==== design/window_sequencer.sv ====
module window_sequencer
	import sparse_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic win_valid_i,
	input  map_t ifm_map_i,
	input  map_t fil_map_i,
	input  fil_t filter_id_i,
	input  logic sub_chunk_first_i,
	input  logic sub_chunk_last_i,
	input  logic match_valid_i,
	input  logic match_end_i,
	output logic load_o,
	output map_t mask_o,
	output map_t ifm_map_o,
	output fil_t filter_id_o,
	output logic sub_chunk_start_o,
	output logic sub_chunk_end_o,
	output logic rd_valid_o,
	output logic win_done_o
);

	map_t ifm_r;
	fil_t fil_id_r;
	logic last_r;
	logic start_r;

	//////////////////////////////
	// Encoder load
	//////////////////////////////

	// Encoder captures the mask on the same edge as the window
	assign load_o = win_valid_i;

	// Only positions nonzero in both maps produce a read
	assign mask_o = ifm_map_i & fil_map_i;

	//////////////////////////////
	// Window latch
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (win_valid_i) begin
			ifm_r    <= ifm_map_i;
			fil_id_r <= filter_id_i;
			last_r   <= sub_chunk_last_i;
		end
	end

	// High only in the first emit cycle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			start_r <= 1'b0;
		end else begin
			start_r <= win_valid_i & sub_chunk_first_i;
		end
	end

	assign ifm_map_o         = ifm_r;
	assign filter_id_o       = fil_id_r;
	assign sub_chunk_start_o = start_r;
	assign sub_chunk_end_o   = last_r;

	// Read strobe and done track the encoder directly
	assign rd_valid_o = match_valid_i;
	assign win_done_o = match_end_i;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the sparse chunk reader testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_sparse_chunk_reader \
	-f sparse_chunk_reader.f \
	--Mdir obj_dir -o sim_tb

# Nonzero exit status on any failing run
./obj_dir/sim_tb

// ==== sparse_chunk_reader.f ====
+incdir+design
design/sparse_pkg.sv
design/spmap_prefix_sum.sv
design/match_pri_enc.sv
design/data_addr_calc.sv
design/window_sequencer.sv
design/sparse_chunk_reader.sv
test/sparse_chunk_reader_checker.sv
test/tb_sparse_chunk_reader.sv

// ==== test/sparse_chunk_reader_checker.sv ====
`include "sparse_defs.svh"

module sparse_chunk_reader_checker
	import sparse_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input logic win_valid_i,
	input logic rd_valid_i,
	input logic win_done_i
);

	timeunit 1ns;
	timeprecision 1ps;

	logic busy_q;
	int   age_q;

	// Window in flight and cycles since its strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			age_q  <= 0;
		end else if (win_valid_i) begin
			busy_q <= 1'b1;
			age_q  <= 1;
		end else if (win_done_i) begin
			busy_q <= 1'b0;
			age_q  <= 0;
		end else if (busy_q) begin
			age_q <= age_q + 1;
		end
	end

	//////////////////////////////
	// Properties
	//////////////////////////////

	a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		win_valid_i |-> !busy_q)
		else $error("window strobe while a window is still in progress");

	a_out_needs_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
		(rd_valid_i || win_done_i) |-> busy_q)
		else $error("read or done without a preceding window strobe");

	// Longest window has one read per map bit
	a_done_in_time: assert property (@(posedge clk_i) disable iff (rst_i)
		busy_q |-> (age_q <= `MAP_WIDTH))
		else $error("done pulse missing within MAP_WIDTH cycles of the strobe");

	a_quiet_in_reset: assert property (@(posedge clk_i)
		rst_i |=> (!rd_valid_i && !win_done_i))
		else $error("outputs active after a reset edge");

endmodule

bind sparse_chunk_reader sparse_chunk_reader_checker u_chk (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.win_valid_i (win_valid_i),
	.rd_valid_i  (rd_valid_o),
	.win_done_i  (win_done_o)
);

// ==== test/tb_sparse_chunk_reader.sv ====
`include "sparse_defs.svh"

module tb_sparse_chunk_reader
	import sparse_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Windows over all directed cases plus the random stream
	localparam int NUM_WINDOWS = 1 + 2 + 6 + 7 + 5 + 200;
	localparam int CYCLE_LIMIT = NUM_WINDOWS * (`MAP_WIDTH + 2) + 100;

	logic        clk_i = 1'b0;
	logic        rst_i;
	logic        win_valid_i;
	map_t        ifm_map_i;
	map_t        fil_map_i;
	fil_t        filter_id_i;
	logic        sub_chunk_first_i;
	logic        sub_chunk_last_i;
	logic        rd_valid_o;
	addr_t       rd_addr_o;
	logic        win_done_o;

	// Reference model state
	addr_t       ref_base;
	addr_t       ref_table [`FILTER_SLOTS];
	addr_t       exp_addr_q [$];
	logic [31:0] lfsr_q;
	int          cycle_cnt = 0;

	sparse_chunk_reader dut_i (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.win_valid_i       (win_valid_i),
		.ifm_map_i         (ifm_map_i),
		.fil_map_i         (fil_map_i),
		.filter_id_i       (filter_id_i),
		.sub_chunk_first_i (sub_chunk_first_i),
		.sub_chunk_last_i  (sub_chunk_last_i),
		.rd_valid_o        (rd_valid_o),
		.rd_addr_o         (rd_addr_o),
		.win_done_o        (win_done_o)
	);

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			stop_run($sformatf("Timeout: the test did not end within %0d cycles", cycle_cnt));
		end
	end

	//////////////////////////////
	// Reporting and compares
	//////////////////////////////

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input int idx);
		if (got !== exp) begin
			stop_run($sformatf("FAIL t=%0t read %0d: rd_addr_o got %0d expected %0d",
				$time, idx, got, exp));
		end
	endtask

	task automatic check_count(input cnt_t got, input cnt_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAIL t=%0t rd_valid_o cycles got %0d expected %0d",
				$time, got, exp));
		end
	endtask

	task automatic check_done(input logic got, input logic exp, input int cyc);
		if (got !== exp) begin
			stop_run($sformatf("FAIL t=%0t win_done_o got %b expected %b in cycle N+%0d",
				$time, got, exp, cyc));
		end
	endtask

	//////////////////////////////
	// Stimulus source
	//////////////////////////////

	// Galois form stepped once per bit taken
	function automatic logic rand_bit();
		logic lsb;
		lsb = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (lsb) begin
			lfsr_q = lfsr_q ^ 32'h8020_0003;
		end
		return lsb;
	endfunction

	function automatic map_t rand_map();
		map_t m;
		for (int i = 0; i < `MAP_WIDTH; i++) begin
			m[i] = rand_bit();
		end
		return m;
	endfunction

	function automatic fil_t rand_fil();
		fil_t f;
		for (int i = 0; i < $bits(fil_t); i++) begin
			f[i] = rand_bit();
		end
		return f;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	task automatic reset_model();
		ref_base = '0;
		for (int f = 0; f < `FILTER_SLOTS; f++) begin
			ref_table[f] = '0;
		end
	endtask

	// Address = base + feature nonzeros below the matched position
	task automatic predict_window(input map_t ifm, input map_t fil, input fil_t fid,
			input logic first, input logic last);
		addr_t start;
		addr_t below;
		exp_addr_q.delete();
		if (first) begin
			start = (fid == '0) ? '0 : ref_table[fid - fil_t'(1)];
		end else begin
			start = ref_base;
		end
		below = '0;
		for (int p = 0; p < `MAP_WIDTH; p++) begin
			if (ifm[p] && fil[p]) begin
				exp_addr_q.push_back(start + below);
			end
			if (ifm[p]) begin
				below = below + addr_t'(1);
			end
		end
		ref_base = start + below;
		if (last) begin
			ref_table[fid] = ref_base;
		end
	endtask

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic apply_reset();
		@(posedge clk_i);
		rst_i       <= 1'b1;
		win_valid_i <= 1'b0;
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		reset_model();
	endtask

	// Strobe one window, then follow reads until the done pulse
	task automatic run_window(input map_t ifm, input map_t fil, input fil_t fid,
			input logic first, input logic last);
		int k;
		int done_cyc;
		int cyc;
		int n_valid;
		logic seen_done;
		predict_window(ifm, fil, fid, first, last);
		k = exp_addr_q.size();
		done_cyc = (k == 0) ? 1 : k;
		cyc = 0;
		n_valid = 0;
		seen_done = 1'b0;
		@(posedge clk_i);
		win_valid_i       <= 1'b1;
		ifm_map_i         <= ifm;
		fil_map_i         <= fil;
		filter_id_i       <= fid;
		sub_chunk_first_i <= first;
		sub_chunk_last_i  <= last;
		@(posedge clk_i);
		win_valid_i <= 1'b0;
		while (!seen_done) begin
			@(negedge clk_i);
			cyc++;
			if (rd_valid_o) begin
				if (n_valid < k) begin
					check_addr(rd_addr_o, exp_addr_q[n_valid], n_valid);
				end
				n_valid++;
			end
			check_done(win_done_o, cyc == done_cyc, cyc);
			seen_done = win_done_o;
		end
		check_count(cnt_t'(n_valid), cnt_t'(k));
	endtask

	//////////////////////////////
	// Directed cases
	//////////////////////////////

	task automatic full_window();
		run_window(8'hff, 8'hff, 2'd0, 1'b1, 1'b1);
	endtask

	// Base still moves by the feature popcount when nothing matches
	task automatic disjoint_maps();
		run_window(8'b1011_0101, 8'b0100_1010, 2'd0, 1'b0, 1'b0);
		run_window(8'h0f, 8'h0f, 2'd0, 1'b0, 1'b1);
	endtask

	task automatic sub_chunk_accumulate();
		for (int w = 0; w < 6; w++) begin
			run_window(rand_map(), rand_map(), 2'd3, w == 0, w == 5);
		end
	endtask

	// Filter 1 again must start where filter 0 ended
	task automatic channel_stacking();
		apply_reset();
		for (int f = 0; f < 3; f++) begin
			run_window(rand_map() | map_t'(1), rand_map() | map_t'(1), fil_t'(f), 1'b1, 1'b0);
			run_window(rand_map(), rand_map(), fil_t'(f), 1'b0, 1'b1);
		end
		run_window(8'hff, 8'hff, 2'd1, 1'b1, 1'b1);
	endtask

	task automatic mid_stream_reset();
		run_window(rand_map(), rand_map(), 2'd0, 1'b1, 1'b1);
		run_window(rand_map(), rand_map(), 2'd1, 1'b1, 1'b1);
		// Abandon a window halfway through its reads
		@(posedge clk_i);
		win_valid_i <= 1'b1;
		ifm_map_i   <= 8'hff;
		fil_map_i   <= 8'hff;
		@(posedge clk_i);
		win_valid_i <= 1'b0;
		repeat (3) @(posedge clk_i);
		apply_reset();
		run_window(8'hff, 8'hff, 2'd2, 1'b0, 1'b1);
		run_window(8'hff, 8'h0f, 2'd1, 1'b1, 1'b0);
	endtask

	task automatic random_stream();
		map_t ifm;
		map_t fil;
		fil_t fid;
		logic first;
		logic last;
		for (int w = 0; w < 200; w++) begin
			ifm = rand_map();
			fil = rand_map();
			fid = rand_fil();
			first = rand_bit();
			last = rand_bit();
			run_window(ifm, fil, fid, first, last);
		end
	endtask

	initial begin
		rst_i             <= 1'b1;
		win_valid_i       <= 1'b0;
		ifm_map_i         <= '0;
		fil_map_i         <= '0;
		filter_id_i       <= '0;
		sub_chunk_first_i <= 1'b0;
		sub_chunk_last_i  <= 1'b0;
		lfsr_q = 32'hbaa2_8c3d;
		reset_model();
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		full_window();
		disjoint_maps();
		sub_chunk_accumulate();
		channel_stacking();
		mid_stream_reset();
		random_stream();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
